// ==== hdl/tempSensorPkg.sv ====
package tempSensorPkg;

    // FSM_Clk cycles per quarter of an SCL bit
    localparam int unsigned QuarterCycles = 2;

    // prescaler width, at least one bit
    localparam int unsigned QuarterBits =
        (QuarterCycles > 1) ? $clog2(QuarterCycles) : 1;

    // 7-bit sensor address 1001000 held in a byte
    localparam logic [7:0] SensorAddr = 8'b0100_1000;

    // temperature register pointer
    localparam logic [7:0] PointerReg = 8'h00;

    // operations in one temperature read
    localparam int unsigned NumOps = 8;

    // bus engine operation codes
    localparam int unsigned OpBits = 2;

    localparam logic [OpBits-1:0] OpStart = 2'd0;
    localparam logic [OpBits-1:0] OpStop = 2'd1;
    localparam logic [OpBits-1:0] OpWrite = 2'd2;
    localparam logic [OpBits-1:0] OpRead = 2'd3;

    // byte view as it arrives on the bus
    typedef struct packed {
        logic [7:0] msb;
        logic [7:0] lsb;
    } tempRaw_s;

    // sensor view, 13-bit code with status flags below it
    typedef struct packed {
        logic [12:0] code;
        logic [2:0] flags;
    } tempSensor_s;

    typedef union packed {
        tempRaw_s raw;
        tempSensor_s sensor;
    } tempWord_u;

endpackage

// ==== hdl/busByteEngine.sv ====
`timescale 1ns/1ns

module busByteEngine (
    input logic FSM_Clk,
    input logic rstN,
    input logic opStrobe,
    input logic [tempSensorPkg::OpBits-1:0] opCode,
    input logic [7:0] txByte,
    input logic masterAck,
    output logic opDone,
    output logic [7:0] rxByte,
    output logic slaveAck,
    output logic scl,
    output logic sdaPull,
    input logic sdaIn
);
    import tempSensorPkg::*;

    logic busy;
    logic [OpBits-1:0] curOp;
    logic [QuarterBits-1:0] preCnt;
    logic [1:0] quarter;
    logic [3:0] bitCnt;
    logic [7:0] shiftReg;
    logic ackBit;
    logic sampleBit;
    logic quarterEnd;
    logic isByteOp;
    logic lastQuarter;
    logic sclNext;
    logic pullNext;

    assign quarterEnd = busy && (preCnt == QuarterBits'(QuarterCycles - 1));
    assign isByteOp = (curOp == OpWrite) || (curOp == OpRead);
    // bit 8 is the acknowledge slot
    assign lastQuarter = (quarter == 2'd3) && (!isByteOp || (bitCnt == 4'd8));
    assign rxByte = shiftReg;

    // bus levels for the current quarter
    always_comb begin
        sclNext = (quarter == 2'd1) || (quarter == 2'd2);
        pullNext = 1'b0;
        case (curOp)
            OpStart: begin
                // high, high, high with SDA falling, then SCL low
                sclNext = (quarter != 2'd3);
                pullNext = quarter[1];
            end
            OpStop: begin
                sclNext = (quarter != 2'd0);
                pullNext = !quarter[1];
            end
            OpWrite: begin
                pullNext = (bitCnt != 4'd8) && !shiftReg[7];
            end
            default: begin
                // read, drive only the master acknowledge
                pullNext = (bitCnt == 4'd8) && !ackBit;
            end
        endcase
    end

    always_ff @(posedge FSM_Clk or negedge rstN) begin
        if (!rstN) begin
            busy <= 1'b0;
            curOp <= OpStop;
            preCnt <= '0;
            quarter <= 2'd0;
            bitCnt <= 4'd0;
            opDone <= 1'b0;
            scl <= 1'b1;
            sdaPull <= 1'b0;
        end else begin
            opDone <= 1'b0;
            if (!busy) begin
                if (opStrobe) begin
                    busy <= 1'b1;
                    curOp <= opCode;
                    preCnt <= '0;
                    quarter <= 2'd0;
                    bitCnt <= 4'd0;
                end
            end else begin
                // outputs trail the quarter state by one cycle
                scl <= sclNext;
                sdaPull <= pullNext;
                if (quarterEnd) begin
                    preCnt <= '0;
                    if (lastQuarter) begin
                        busy <= 1'b0;
                        opDone <= 1'b1;
                    end else begin
                        quarter <= quarter + 2'd1;
                        if (quarter == 2'd3) begin
                            bitCnt <= bitCnt + 4'd1;
                        end
                    end
                end else begin
                    preCnt <= preCnt + 1'b1;
                end
            end
        end
    end

    // data path
    always_ff @(posedge FSM_Clk) begin
        if (!busy && opStrobe) begin
            shiftReg <= txByte;
            ackBit <= masterAck;
        end else if (quarterEnd) begin
            // sample at the end of the third quarter, SCL high
            if (quarter == 2'd2) begin
                if (bitCnt == 4'd8) begin
                    slaveAck <= sdaIn;
                end else begin
                    sampleBit <= sdaIn;
                end
            end
            // shift once SCL is low again
            if ((quarter == 2'd3) && isByteOp && (bitCnt != 4'd8)) begin
                shiftReg <= {shiftReg[6:0], sampleBit};
            end
        end
    end

endmodule

// ==== hdl/readSequencer.sv ====
`timescale 1ns/1ns

module readSequencer (
    input logic FSM_Clk,
    input logic rstN,
    input logic req,
    output logic ack,
    output logic opStrobe,
    output logic [tempSensorPkg::OpBits-1:0] opCode,
    output logic [7:0] txByte,
    output logic masterAck,
    input logic opDone,
    input logic slaveAck,
    output logic clear,
    output logic loadMsb,
    output logic loadLsb,
    output logic nackPulse
);
    import tempSensorPkg::*;

    // 0 while idle, otherwise the operation in flight
    logic [3:0] step;
    logic addrStep;

    // operation for each step of the read
    always_comb begin
        opCode = OpStop;
        txByte = PointerReg;
        masterAck = 1'b0;
        case (step)
            4'd1: begin
                opCode = OpStart;
            end
            4'd2: begin
                opCode = OpWrite;
                txByte = {SensorAddr[6:0], 1'b0};
            end
            4'd3: begin
                opCode = OpWrite;
                txByte = PointerReg;
            end
            4'd4: begin
                // repeated start
                opCode = OpStart;
            end
            4'd5: begin
                opCode = OpWrite;
                txByte = {SensorAddr[6:0], 1'b1};
            end
            4'd6: begin
                opCode = OpRead;
                masterAck = 1'b0;
            end
            4'd7: begin
                // last byte, release SDA
                opCode = OpRead;
                masterAck = 1'b1;
            end
            default: begin
                opCode = OpStop;
            end
        endcase
    end

    // steps where the sensor owes an acknowledge
    assign addrStep = (step == 4'd2) || (step == 4'd3) || (step == 4'd5);

    assign loadMsb = opDone && (step == 4'd6);
    assign loadLsb = opDone && (step == 4'd7);
    assign nackPulse = opDone && addrStep && slaveAck;

    always_ff @(posedge FSM_Clk or negedge rstN) begin
        if (!rstN) begin
            step <= 4'd0;
            ack <= 1'b0;
            opStrobe <= 1'b0;
            clear <= 1'b0;
        end else begin
            opStrobe <= 1'b0;
            clear <= 1'b0;
            if (ack) begin
                // bus stays idle until req drops
                if (!req) begin
                    ack <= 1'b0;
                end
            end else if (step == 4'd0) begin
                if (req) begin
                    step <= 4'd1;
                    opStrobe <= 1'b1;
                    clear <= 1'b1;
                end
            end else if (opDone) begin
                if (step == 4'(NumOps)) begin
                    step <= 4'd0;
                    ack <= 1'b1;
                end else begin
                    step <= step + 4'd1;
                    opStrobe <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== hdl/tempResult.sv ====
`timescale 1ns/1ns

module tempResult (
    input logic FSM_Clk,
    input logic rstN,
    input logic clear,
    input logic loadMsb,
    input logic loadLsb,
    input logic nackPulse,
    input logic [7:0] rxByte,
    output tempSensorPkg::tempWord_u tempWord,
    output logic nackSeen
);
    import tempSensorPkg::*;

    tempWord_u nextWord;

    // bytes land through the raw view
    always_comb begin
        nextWord = tempWord;
        if (clear) begin
            nextWord = '0;
        end
        if (loadMsb) begin
            nextWord.raw.msb = rxByte;
        end
        if (loadLsb) begin
            nextWord.raw.lsb = rxByte;
        end
    end

    always_ff @(posedge FSM_Clk or negedge rstN) begin
        if (!rstN) begin
            tempWord <= '0;
            nackSeen <= 1'b0;
        end else begin
            tempWord <= nextWord;
            // sticky for the whole transaction
            if (clear) begin
                nackSeen <= 1'b0;
            end else if (nackPulse) begin
                nackSeen <= 1'b1;
            end
        end
    end

endmodule

// ==== hdl/tempSensorReader.sv ====
`timescale 1ns/1ns

module tempSensorReader (
    input logic FSM_Clk,
    input logic rstN,
    input logic req,
    output logic ack,
    output logic scl,
    output logic sdaPull,
    input logic sdaIn,
    output tempSensorPkg::tempWord_u tempWord,
    output logic nackSeen
);
    import tempSensorPkg::*;

    // sequencer to engine
    logic opStrobe;
    logic [OpBits-1:0] opCode;
    logic [7:0] txByte;
    logic masterAck;
    logic opDone;
    logic [7:0] rxByte;
    logic slaveAck;

    // sequencer to result
    logic clear;
    logic loadMsb;
    logic loadLsb;
    logic nackPulse;

    readSequencer seq0 (
        .FSM_Clk(FSM_Clk),
        .rstN(rstN),
        .req(req),
        .ack(ack),
        .opStrobe(opStrobe),
        .opCode(opCode),
        .txByte(txByte),
        .masterAck(masterAck),
        .opDone(opDone),
        .slaveAck(slaveAck),
        .clear(clear),
        .loadMsb(loadMsb),
        .loadLsb(loadLsb),
        .nackPulse(nackPulse)
    );

    busByteEngine engine0 (
        .FSM_Clk(FSM_Clk),
        .rstN(rstN),
        .opStrobe(opStrobe),
        .opCode(opCode),
        .txByte(txByte),
        .masterAck(masterAck),
        .opDone(opDone),
        .rxByte(rxByte),
        .slaveAck(slaveAck),
        .scl(scl),
        .sdaPull(sdaPull),
        .sdaIn(sdaIn)
    );

    tempResult result0 (
        .FSM_Clk(FSM_Clk),
        .rstN(rstN),
        .clear(clear),
        .loadMsb(loadMsb),
        .loadLsb(loadLsb),
        .nackPulse(nackPulse),
        .rxByte(rxByte),
        .tempWord(tempWord),
        .nackSeen(nackSeen)
    );

endmodule

// ==== tb/sensorModel.sv ====
`timescale 1ns/1ns

module sensorModel (
    input logic FSM_Clk,
    input logic rstN,
    input logic scl,
    input logic sdaPull,
    input logic withholdAck,
    output logic sdaIn,
    output int stopCount,
    output int startsAtStop,
    output logic [23:0] rxLog,
    output logic [1:0] masterAckLog,
    output logic [15:0] sentWord
);
    import tempSensorPkg::*;

    logic [31:0] lcgState;
    logic modelPull;
    logic prevScl;
    logic prevBus;
    logic active;
    logic sclHigh;
    logic receiving;
    logic toRead;
    logic silent;
    logic readIdx;
    logic [3:0] bitIdx;
    logic [7:0] inByte;
    logic [7:0] outByte;
    int startsSinceStop;

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // bus watched and answered on the falling clock edge
    always @(negedge FSM_Clk or negedge rstN) begin
        logic busNow;
        logic pullNext;
        logic [31:0] nextState;
        logic [7:0] nextByte;
        if (!rstN) begin
            lcgState <= 32'd23;
            modelPull <= 1'b0;
            prevScl <= 1'b1;
            prevBus <= 1'b1;
            active <= 1'b0;
            sdaIn <= 1'b1;
            stopCount <= 0;
            startsSinceStop <= 0;
        end else begin
            // wired AND with pull-up
            busNow = !(sdaPull || modelPull);
            pullNext = modelPull;
            prevScl <= scl;
            prevBus <= busNow;
            if (prevScl && scl && prevBus && !busNow) begin
                startsSinceStop <= startsSinceStop + 1;
                active <= 1'b1;
                receiving <= 1'b1;
                toRead <= 1'b0;
                sclHigh <= 1'b0;
                bitIdx <= 4'd0;
                pullNext = 1'b0;
            end else if (prevScl && scl && !prevBus && busNow) begin
                stopCount <= stopCount + 1;
                startsAtStop <= startsSinceStop;
                startsSinceStop <= 0;
                active <= 1'b0;
            end else if (active && !prevScl && scl) begin
                sclHigh <= 1'b1;
                if (receiving && bitIdx != 4'd8)
                    inByte <= {inByte[6:0], busNow};
                if (!receiving && bitIdx == 4'd8)
                    masterAckLog <= {masterAckLog[0], !busNow};
            end else if (active && sclHigh && prevScl && !scl) begin
                sclHigh <= 1'b0;
                bitIdx <= (bitIdx == 4'd8) ? 4'd0 : bitIdx + 4'd1;
                if (bitIdx == 4'd7) begin
                    // ack slot, released while the master answers
                    pullNext = receiving;
                    if (receiving) begin
                        rxLog <= {rxLog[15:0], inByte};
                        if (inByte == {SensorAddr[6:0], 1'b1}) begin
                            toRead <= 1'b1;
                            silent <= withholdAck;
                            pullNext = !withholdAck;
                            if (!withholdAck) begin
                                nextState = lcgNext(lcgState);
                                lcgState <= nextState;
                                sentWord <= nextState[31:16];
                            end
                        end
                    end
                end else if (bitIdx == 4'd8) begin
                    pullNext = 1'b0;
                    if (toRead || (!receiving && !readIdx)) begin
                        // high byte first, then low byte
                        nextByte = toRead ? sentWord[15:8] : sentWord[7:0];
                        pullNext = !silent && !nextByte[7];
                        outByte <= {nextByte[6:0], 1'b0};
                        receiving <= 1'b0;
                        toRead <= 1'b0;
                        readIdx <= !toRead;
                    end
                end else if (!receiving) begin
                    pullNext = !silent && !outByte[7];
                    outByte <= {outByte[6:0], 1'b0};
                end
            end
            modelPull <= pullNext;
            sdaIn <= !(sdaPull || pullNext);
        end
    end

endmodule

// ==== tb/tempSensorReader_props.sv ====
`timescale 1ns/1ns

module tempSensorReaderProps (
    input logic FSM_Clk,
    input logic rstN,
    input logic req,
    input logic ack,
    input logic scl,
    input logic sdaPull
);

    ackRise: assert property (@(posedge FSM_Clk) disable iff (!rstN)
        $rose(ack) |-> $past(req))
        else $error("ack rose without a pending req");

    ackFall: assert property (@(posedge FSM_Clk) disable iff (!rstN)
        $fell(ack) |-> !$past(req))
        else $error("ack fell while req was still high");

    // bus parked while no read runs
    busIdle: assert property (@(posedge FSM_Clk) disable iff (!rstN)
        (ack || !$past(req)) |-> (scl && !sdaPull))
        else $error("bus not idle outside a transaction");

    // SDA and SCL never move together
    pullVsScl: assert property (@(posedge FSM_Clk) disable iff (!rstN)
        (sdaPull != $past(sdaPull)) |-> (scl == $past(scl)))
        else $error("sdaPull and scl changed in the same cycle");

endmodule

bind tempSensorReader tempSensorReaderProps props0 (
    .FSM_Clk(FSM_Clk),
    .rstN(rstN),
    .req(req),
    .ack(ack),
    .scl(scl),
    .sdaPull(sdaPull)
);

// ==== tb/tempSensorReaderTb.sv ====
`timescale 1ns/1ns

module tempSensorReaderTb;
    import tempSensorPkg::*;

    localparam int unsigned NumReads = 6;
    // quarters per read with margin, doubled
    localparam int unsigned CycleLimit =
        NumReads * (2 * 4 + 5 * 36 + 8) * QuarterCycles * 2;

    logic FSM_Clk;
    logic rstN;
    logic req;
    logic ack;
    logic scl;
    logic sdaPull;
    logic sdaIn;
    logic nackSeen;
    logic withholdAck;
    tempWord_u tempWord;
    int stopCount;
    int startsAtStop;
    logic [23:0] rxLog;
    logic [1:0] masterAckLog;
    logic [15:0] sentWord;
    int unsigned cycles = 0;
    int errors = 0;
    int testErrors = 0;
    int testCount = 0;

    tempSensorReader dut0 (.*);

    sensorModel model0 (.*);

    initial begin
        FSM_Clk = 1'b0;
        forever #10 FSM_Clk = ~FSM_Clk;
    end

    always @(posedge FSM_Clk) begin
        cycles <= cycles + 1;
        if (cycles >= CycleLimit) begin
            $display("timeout, no ack from the DUT within %0d cycles", cycles);
            $display("Checks failed");
            $finish;
        end
    end

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got == exp) else begin
            $display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, exp);
            testErrors++;
        end
    endtask

    task automatic endTest(input string name);
        if (testErrors == 0)
            $display("test %s: ok", name);
        else
            $display("test %s: %0d errors", name, testErrors);
        errors += testErrors;
        testErrors = 0;
        testCount++;
    endtask

    // one full four-phase read
    task automatic readOnce(input logic withhold);
        int stopsBefore;
        stopsBefore = stopCount;
        withholdAck = withhold;
        req = 1'b1;
        @(negedge FSM_Clk);
        while (!ack)
            @(negedge FSM_Clk);
        checkValue("stopCount", 32'(stopCount - stopsBefore), 32'd1);
        checkValue("startsAtStop", 32'(startsAtStop), 32'd2);
        checkValue("rxLog", 32'(rxLog),
                   32'({SensorAddr[6:0], 1'b0, PointerReg, SensorAddr[6:0], 1'b1}));
        // high byte acked, low byte not
        checkValue("masterAckLog", 32'(masterAckLog), 32'd2);
        checkValue("nackSeen", 32'(nackSeen), 32'(withhold));
        if (withhold) begin
            checkValue("tempWord", 32'({tempWord.raw.msb, tempWord.raw.lsb}), 32'hffff);
        end else begin
            checkValue("tempWord.raw.msb", 32'(tempWord.raw.msb), 32'(sentWord[15:8]));
            checkValue("tempWord.raw.lsb", 32'(tempWord.raw.lsb), 32'(sentWord[7:0]));
            checkValue("tempWord.sensor.code", 32'(tempWord.sensor.code),
                       32'(sentWord[15:3]));
            checkValue("tempWord.sensor.flags", 32'(tempWord.sensor.flags),
                       32'(sentWord[2:0]));
        end
        req = 1'b0;
        @(negedge FSM_Clk);
        while (ack)
            @(negedge FSM_Clk);
    endtask

    initial begin
        rstN = 1'b0;
        req = 1'b0;
        withholdAck = 1'b0;
        repeat (5) @(negedge FSM_Clk);
        rstN = 1'b1;
        // req stays low, nothing may start
        repeat (4) @(negedge FSM_Clk);
        checkValue("ack", 32'(ack), 32'd0);
        checkValue("scl", 32'(scl), 32'd1);
        checkValue("sdaPull", 32'(sdaPull), 32'd0);
        checkValue("tempWord", 32'({tempWord.raw.msb, tempWord.raw.lsb}), 32'd0);
        checkValue("nackSeen", 32'(nackSeen), 32'd0);
        endTest("reset");
        for (int i = 0; i < 4; i++) begin
            readOnce(1'b0);
            endTest($sformatf("read %0d", i));
        end
        readOnce(1'b1);
        endTest("withheld ack");
        readOnce(1'b0);
        endTest("nack cleared");
        $display("%0d tests, %0d errors", testCount, errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

// ==== all.f ====
hdl/tempSensorPkg.sv
hdl/busByteEngine.sv
hdl/readSequencer.sv
hdl/tempResult.sv
hdl/tempSensorReader.sv
tb/sensorModel.sv
tb/tempSensorReader_props.sv
tb/tempSensorReaderTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tempSensorReaderTb -Mdir obj_dir -f all.f
./obj_dir/VtempSensorReaderTb > sim.log
cat sim.log

if grep -q "Checks failed" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
echo "simulation ok"
